/* build.f */
rtl/csr_pkg.sv
rtl/csr_except_regs.sv
rtl/csr_timer.sv
rtl/csr_int_combine.sv
rtl/csr_regfile.sv
tb/csr_regfile_tb.sv

/* rtl/csr_except_regs.sv */
`default_nettype none

module csr_except_regs #(
    parameter int SAVE_COUNT = 4
) (
    input  wire                                 clk,
    input  wire                                 reset,
    input  wire csr_pkg::csr_addr_t             csr_raddr,
    input  wire                                 csr_we,
    input  wire csr_pkg::csr_addr_t             csr_waddr,
    input  wire csr_pkg::csr_data_t             csr_wmask,
    input  wire csr_pkg::csr_data_t             csr_wdata,
    input  wire                                 wb_ex,
    input  wire csr_pkg::ecode_t                wb_ecode,
    input  wire csr_pkg::esubcode_t             wb_esubcode,
    input  wire csr_pkg::csr_data_t             wb_pc,
    input  wire                                 ertn_flush,
    input  wire [csr_pkg::HW_INT_COUNT-1:0]     hw_int_in,
    input  wire                                 ipi_int_in,
    output csr_pkg::csr_data_t                  except_rdata,
    output csr_pkg::int_vec_t                   int_status,
    output csr_pkg::int_vec_t                   int_enable,
    output logic                                global_ie,
    output csr_pkg::csr_data_t                  ex_entry,
    output csr_pkg::plv_t                       crmd_plv
);

    logic                                crmd_da;
    logic                                crmd_pg;
    logic [1:0]                          crmd_datf;
    logic [1:0]                          crmd_datm;
    csr_pkg::plv_t                       prmd_pplv;
    logic                                prmd_pie;
    logic [csr_pkg::HW_INT_LSB-1:0]      sw_int;
    logic [csr_pkg::HW_INT_COUNT-1:0]    hw_int;
    logic                                ipi_int;
    csr_pkg::ecode_t                     estat_ecode;
    csr_pkg::esubcode_t                  estat_esubcode;
    csr_pkg::csr_data_t                  era_pc;
    logic [31:csr_pkg::EENTRY_VA_LSB]    eentry_va;
    csr_pkg::csr_data_t                  save_data [SAVE_COUNT];
    csr_pkg::csr_data_t                  crmd_value;
    csr_pkg::csr_data_t                  prmd_value;
    csr_pkg::csr_data_t                  estat_value;
    csr_pkg::csr_data_t                  crmd_next;
    csr_pkg::csr_data_t                  prmd_next;
    csr_pkg::csr_data_t                  ecfg_next;
    csr_pkg::csr_data_t                  estat_next;
    csr_pkg::csr_data_t                  era_next;
    csr_pkg::csr_data_t                  eentry_next;

    wire crmd_wr   = csr_we && csr_waddr == csr_pkg::CSR_CRMD;
    wire prmd_wr   = csr_we && csr_waddr == csr_pkg::CSR_PRMD;
    wire ecfg_wr   = csr_we && csr_waddr == csr_pkg::CSR_ECFG;
    wire estat_wr  = csr_we && csr_waddr == csr_pkg::CSR_ESTAT;
    wire era_wr    = csr_we && csr_waddr == csr_pkg::CSR_ERA;
    wire eentry_wr = csr_we && csr_waddr == csr_pkg::CSR_EENTRY;

    always_comb begin
        int_status = '0;
        int_status[csr_pkg::HW_INT_LSB-1:0] = sw_int;
        int_status[csr_pkg::HW_INT_LSB +: csr_pkg::HW_INT_COUNT] = hw_int;
        int_status[csr_pkg::IPI_BIT] = ipi_int;
    end

    always_comb begin
        crmd_value = '0;
        crmd_value[csr_pkg::CRMD_PLV_MSB:csr_pkg::CRMD_PLV_LSB] = crmd_plv;
        crmd_value[csr_pkg::CRMD_IE] = global_ie;
        crmd_value[csr_pkg::CRMD_DA] = crmd_da;
        crmd_value[csr_pkg::CRMD_PG] = crmd_pg;
        crmd_value[csr_pkg::CRMD_DATF_MSB:csr_pkg::CRMD_DATF_LSB] = crmd_datf;
        crmd_value[csr_pkg::CRMD_DATM_MSB:csr_pkg::CRMD_DATM_LSB] = crmd_datm;
        prmd_value = '0;
        prmd_value[csr_pkg::PRMD_PPLV_MSB:csr_pkg::PRMD_PPLV_LSB] = prmd_pplv;
        prmd_value[csr_pkg::PRMD_PIE] = prmd_pie;
        // Timer bit 11 stays zero here and comes from the timer
        estat_value = '0;
        estat_value[csr_pkg::ESTAT_IS_MSB:csr_pkg::ESTAT_IS_LSB] = int_status;
        estat_value[csr_pkg::ESTAT_ECODE_MSB:csr_pkg::ESTAT_ECODE_LSB] = estat_ecode;
        estat_value[csr_pkg::ESTAT_SUBCODE_MSB:csr_pkg::ESTAT_SUBCODE_LSB] = estat_esubcode;
    end

    assign ex_entry    = {eentry_va, {csr_pkg::EENTRY_VA_LSB{1'b0}}};
    assign crmd_next   = csr_pkg::wr_merge(crmd_value, csr_wmask, csr_wdata);
    assign prmd_next   = csr_pkg::wr_merge(prmd_value, csr_wmask, csr_wdata);
    assign ecfg_next   = csr_pkg::wr_merge(32'(int_enable), csr_wmask, csr_wdata);
    assign estat_next  = csr_pkg::wr_merge(estat_value, csr_wmask, csr_wdata);
    assign era_next    = csr_pkg::wr_merge(era_pc, csr_wmask, csr_wdata);
    assign eentry_next = csr_pkg::wr_merge(ex_entry, csr_wmask, csr_wdata);

    // Entry wins over return and over a CSR write
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_plv  <= '0;
            global_ie <= 1'b0;
            crmd_da   <= 1'b1;
            crmd_pg   <= 1'b0;
            crmd_datf <= '0;
            crmd_datm <= '0;
        end else if (wb_ex) begin
            crmd_plv  <= '0;
            global_ie <= 1'b0;
        end else if (ertn_flush) begin
            crmd_plv  <= prmd_pplv;
            global_ie <= prmd_pie;
        end else if (crmd_wr) begin
            crmd_plv  <= crmd_next[csr_pkg::CRMD_PLV_MSB:csr_pkg::CRMD_PLV_LSB];
            global_ie <= crmd_next[csr_pkg::CRMD_IE];
            crmd_da   <= crmd_next[csr_pkg::CRMD_DA];
            crmd_pg   <= crmd_next[csr_pkg::CRMD_PG];
            crmd_datf <= crmd_next[csr_pkg::CRMD_DATF_MSB:csr_pkg::CRMD_DATF_LSB];
            crmd_datm <= crmd_next[csr_pkg::CRMD_DATM_MSB:csr_pkg::CRMD_DATM_LSB];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            int_enable <= '0;
            sw_int     <= '0;
            hw_int     <= '0;
            ipi_int    <= 1'b0;
        end else begin
            if (ecfg_wr) begin
                int_enable <= ecfg_next[csr_pkg::ECFG_LIE_MSB:csr_pkg::ECFG_LIE_LSB]
                            & csr_pkg::ECFG_LIE_MASK;
            end
            if (estat_wr) begin
                sw_int <= estat_next[csr_pkg::HW_INT_LSB-1:0];
            end
            hw_int  <= hw_int_in;
            ipi_int <= ipi_int_in;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_ex) begin
            prmd_pplv      <= crmd_plv;
            prmd_pie       <= global_ie;
            estat_ecode    <= wb_ecode;
            estat_esubcode <= wb_esubcode;
            era_pc         <= wb_pc;
        end else begin
            if (prmd_wr) begin
                prmd_pplv <= prmd_next[csr_pkg::PRMD_PPLV_MSB:csr_pkg::PRMD_PPLV_LSB];
                prmd_pie  <= prmd_next[csr_pkg::PRMD_PIE];
            end
            if (era_wr) begin
                era_pc <= era_next;
            end
        end
        if (eentry_wr) begin
            eentry_va <= eentry_next[31:csr_pkg::EENTRY_VA_LSB];
        end
        for (int i = 0; i < SAVE_COUNT; i++) begin
            if (csr_we && csr_waddr == csr_pkg::CSR_SAVE0 + csr_pkg::csr_addr_t'(i)) begin
                save_data[i] <= csr_pkg::wr_merge(save_data[i], csr_wmask, csr_wdata);
            end
        end
    end

    always_comb begin
        case (csr_raddr)
            csr_pkg::CSR_CRMD:   except_rdata = crmd_value;
            csr_pkg::CSR_PRMD:   except_rdata = prmd_value;
            csr_pkg::CSR_ECFG:   except_rdata = 32'(int_enable);
            csr_pkg::CSR_ESTAT:  except_rdata = estat_value;
            csr_pkg::CSR_ERA:    except_rdata = era_pc;
            csr_pkg::CSR_EENTRY: except_rdata = ex_entry;
            default:             except_rdata = '0;
        endcase
        // Scratch slots past SAVE_COUNT fall through as zero
        for (int i = 0; i < SAVE_COUNT; i++) begin
            if (csr_raddr == csr_pkg::CSR_SAVE0 + csr_pkg::csr_addr_t'(i)) begin
                except_rdata = save_data[i];
            end
        end
    end

    a_ex_ertn_exclusive: assert property (
        @(posedge clk) disable iff (reset) !(wb_ex && ertn_flush)
    );

endmodule

`default_nettype wire

/* rtl/csr_int_combine.sv */
`default_nettype none

module csr_int_combine (
    input  wire csr_pkg::csr_data_t except_rdata,
    input  wire csr_pkg::csr_data_t timer_rdata,
    input  wire csr_pkg::int_vec_t  int_status,
    input  wire csr_pkg::int_vec_t  int_enable,
    input  wire                     global_ie,
    input  wire                     timer_int,
    output csr_pkg::csr_data_t      csr_rdata,
    output logic                    has_int
);

    csr_pkg::int_vec_t pending;
    csr_pkg::int_vec_t masked;

    // Each side returns zero outside its own addresses
    assign csr_rdata = except_rdata | timer_rdata;

    always_comb begin
        pending = int_status;
        pending[csr_pkg::TIMER_INT_BIT] = timer_int;
    end

    assign masked  = pending & int_enable;
    assign has_int = (masked != '0) && global_ie;

endmodule

`default_nettype wire

/* rtl/csr_pkg.sv */
`default_nettype none

package csr_pkg;

    typedef logic [13:0] csr_addr_t;
    typedef logic [31:0] csr_data_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [8:0]  esubcode_t;
    typedef logic [12:0] int_vec_t;
    typedef logic [1:0]  plv_t;

    // CSR numbers
    localparam csr_addr_t CSR_CRMD   = 14'h000;
    localparam csr_addr_t CSR_PRMD   = 14'h001;
    localparam csr_addr_t CSR_ECFG   = 14'h004;
    localparam csr_addr_t CSR_ESTAT  = 14'h005;
    localparam csr_addr_t CSR_ERA    = 14'h006;
    localparam csr_addr_t CSR_EENTRY = 14'h00c;
    localparam csr_addr_t CSR_SAVE0  = 14'h030;
    localparam csr_addr_t CSR_TCFG   = 14'h041;
    localparam csr_addr_t CSR_TVAL   = 14'h042;
    localparam csr_addr_t CSR_TICLR  = 14'h044;

    localparam int CRMD_PLV_LSB      = 0;
    localparam int CRMD_PLV_MSB      = 1;
    localparam int CRMD_IE           = 2;
    localparam int CRMD_DA           = 3;
    localparam int CRMD_PG           = 4;
    localparam int CRMD_DATF_LSB     = 5;
    localparam int CRMD_DATF_MSB     = 6;
    localparam int CRMD_DATM_LSB     = 7;
    localparam int CRMD_DATM_MSB     = 8;
    localparam int PRMD_PPLV_LSB     = 0;
    localparam int PRMD_PPLV_MSB     = 1;
    localparam int PRMD_PIE          = 2;
    localparam int ECFG_LIE_LSB      = 0;
    localparam int ECFG_LIE_MSB      = 12;
    localparam int ESTAT_IS_LSB      = 0;
    localparam int ESTAT_IS_MSB      = 12;
    localparam int ESTAT_ECODE_LSB   = 16;
    localparam int ESTAT_ECODE_MSB   = 21;
    localparam int ESTAT_SUBCODE_LSB = 22;
    localparam int ESTAT_SUBCODE_MSB = 30;
    localparam int TCFG_EN           = 0;
    localparam int TCFG_PERIODIC     = 1;
    localparam int TCFG_INITV_LSB    = 2;
    localparam int TCFG_INITV_MSB    = 31;
    localparam int TICLR_CLR         = 0;
    localparam int EENTRY_VA_LSB     = 6;

    // Interrupt vector layout
    localparam int_vec_t  ECFG_LIE_MASK = 13'h1bff;
    localparam int        HW_INT_LSB    = 2;
    localparam int        HW_INT_COUNT  = 8;
    localparam int        TIMER_INT_BIT = 11;
    localparam int        IPI_BIT       = 12;
    localparam csr_data_t TIMER_IDLE    = 32'hffff_ffff;

    // Bits under a set mask bit take the write data
    function automatic csr_data_t wr_merge(
        input csr_data_t old_value,
        input csr_data_t mask,
        input csr_data_t data
    );
        return (mask & data) | (~mask & old_value);
    endfunction

endpackage

`default_nettype wire

/* rtl/csr_regfile.sv */
`default_nettype none

module csr_regfile #(
    parameter int SAVE_COUNT = 4
) (
    input  wire                             clk,
    input  wire                             reset,
    input  wire csr_pkg::csr_addr_t         csr_raddr,
    input  wire                             csr_we,
    input  wire csr_pkg::csr_addr_t         csr_waddr,
    input  wire csr_pkg::csr_data_t         csr_wmask,
    input  wire csr_pkg::csr_data_t         csr_wdata,
    input  wire                             wb_ex,
    input  wire csr_pkg::ecode_t            wb_ecode,
    input  wire csr_pkg::esubcode_t         wb_esubcode,
    input  wire csr_pkg::csr_data_t         wb_pc,
    input  wire                             ertn_flush,
    input  wire [csr_pkg::HW_INT_COUNT-1:0] hw_int_in,
    input  wire                             ipi_int_in,
    output csr_pkg::csr_data_t              csr_rdata,
    output logic                            has_int,
    output csr_pkg::csr_data_t              ex_entry,
    output csr_pkg::plv_t                   crmd_plv
);

    csr_pkg::csr_data_t except_rdata;
    csr_pkg::csr_data_t timer_rdata;
    csr_pkg::int_vec_t  int_status;
    csr_pkg::int_vec_t  int_enable;
    logic               global_ie;
    logic               timer_int;

    csr_except_regs #(
        .SAVE_COUNT(SAVE_COUNT)
    ) u_except_regs (
        .clk         (clk),
        .reset       (reset),
        .csr_raddr   (csr_raddr),
        .csr_we      (csr_we),
        .csr_waddr   (csr_waddr),
        .csr_wmask   (csr_wmask),
        .csr_wdata   (csr_wdata),
        .wb_ex       (wb_ex),
        .wb_ecode    (wb_ecode),
        .wb_esubcode (wb_esubcode),
        .wb_pc       (wb_pc),
        .ertn_flush  (ertn_flush),
        .hw_int_in   (hw_int_in),
        .ipi_int_in  (ipi_int_in),
        .except_rdata(except_rdata),
        .int_status  (int_status),
        .int_enable  (int_enable),
        .global_ie   (global_ie),
        .ex_entry    (ex_entry),
        .crmd_plv    (crmd_plv)
    );

    csr_timer u_timer (
        .clk        (clk),
        .reset      (reset),
        .csr_raddr  (csr_raddr),
        .csr_we     (csr_we),
        .csr_waddr  (csr_waddr),
        .csr_wmask  (csr_wmask),
        .csr_wdata  (csr_wdata),
        .timer_rdata(timer_rdata),
        .timer_int  (timer_int)
    );

    csr_int_combine u_int_combine (
        .except_rdata(except_rdata),
        .timer_rdata (timer_rdata),
        .int_status  (int_status),
        .int_enable  (int_enable),
        .global_ie   (global_ie),
        .timer_int   (timer_int),
        .csr_rdata   (csr_rdata),
        .has_int     (has_int)
    );

endmodule

`default_nettype wire

/* rtl/csr_timer.sv */
`default_nettype none

module csr_timer (
    input  wire                     clk,
    input  wire                     reset,
    input  wire csr_pkg::csr_addr_t csr_raddr,
    input  wire                     csr_we,
    input  wire csr_pkg::csr_addr_t csr_waddr,
    input  wire csr_pkg::csr_data_t csr_wmask,
    input  wire csr_pkg::csr_data_t csr_wdata,
    output csr_pkg::csr_data_t      timer_rdata,
    output logic                    timer_int
);

    logic                                                  tcfg_en;
    logic                                                  tcfg_periodic;
    logic [csr_pkg::TCFG_INITV_MSB:csr_pkg::TCFG_INITV_LSB] tcfg_initv;
    csr_pkg::csr_data_t                                    timer_cnt;
    csr_pkg::csr_data_t                                    tcfg_value;
    csr_pkg::csr_data_t                                    tcfg_next;

    wire tcfg_wr     = csr_we && csr_waddr == csr_pkg::CSR_TCFG;
    wire ticlr_wr    = csr_we && csr_waddr == csr_pkg::CSR_TICLR;
    wire timer_clear = ticlr_wr && csr_wmask[csr_pkg::TICLR_CLR]
                       && csr_wdata[csr_pkg::TICLR_CLR];

    always_comb begin
        tcfg_value = '0;
        tcfg_value[csr_pkg::TCFG_EN] = tcfg_en;
        tcfg_value[csr_pkg::TCFG_PERIODIC] = tcfg_periodic;
        tcfg_value[csr_pkg::TCFG_INITV_MSB:csr_pkg::TCFG_INITV_LSB] = tcfg_initv;
    end

    assign tcfg_next = csr_pkg::wr_merge(tcfg_value, csr_wmask, csr_wdata);

    always_ff @(posedge clk) begin
        if (reset) begin
            tcfg_en       <= 1'b0;
            tcfg_periodic <= 1'b0;
            tcfg_initv    <= '0;
        end else if (tcfg_wr) begin
            tcfg_en       <= tcfg_next[csr_pkg::TCFG_EN];
            tcfg_periodic <= tcfg_next[csr_pkg::TCFG_PERIODIC];
            tcfg_initv    <= tcfg_next[csr_pkg::TCFG_INITV_MSB:csr_pkg::TCFG_INITV_LSB];
        end
    end

    // One-shot mode wraps from zero to all ones and parks there
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_cnt <= csr_pkg::TIMER_IDLE;
        end else if (tcfg_wr && tcfg_next[csr_pkg::TCFG_EN]) begin
            timer_cnt <= {tcfg_next[csr_pkg::TCFG_INITV_MSB:csr_pkg::TCFG_INITV_LSB], 2'b00};
        end else if (tcfg_en && timer_cnt != csr_pkg::TIMER_IDLE) begin
            if (timer_cnt == '0 && tcfg_periodic) begin
                timer_cnt <= {tcfg_initv, 2'b00};
            end else begin
                timer_cnt <= timer_cnt - 32'd1;
            end
        end
    end

    // Set beats a clear on the same edge
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_int <= 1'b0;
        end else if (timer_cnt == '0) begin
            timer_int <= 1'b1;
        end else if (timer_clear) begin
            timer_int <= 1'b0;
        end
    end

    always_comb begin
        timer_rdata = '0;
        case (csr_raddr)
            csr_pkg::CSR_TCFG:  timer_rdata = tcfg_value;
            csr_pkg::CSR_TVAL:  timer_rdata = timer_cnt;
            csr_pkg::CSR_ESTAT: timer_rdata[csr_pkg::TIMER_INT_BIT] = timer_int;
            default:            timer_rdata = '0;
        endcase
    end

    a_idle_holds: assert property (
        @(posedge clk) disable iff (reset)
        (timer_cnt == csr_pkg::TIMER_IDLE && !tcfg_en && !tcfg_wr)
            |=> timer_cnt == csr_pkg::TIMER_IDLE
    );

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 --timescale 1ns/1ps \
    --top-module csr_regfile_tb -o csr_sim -f build.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/csr_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q ">>> FAIL" "$LOG"; then
    exit 1
fi
exit 0

/* tb/csr_regfile_tb.sv */
`default_nettype none

module csr_regfile_tb;

    timeunit 1ns;
    timeprecision 1ps;

    typedef enum logic [3:0] {
        OP_WRITE, OP_READ, OP_EX, OP_ERTN, OP_IDLE,
        OP_IRQ, OP_INT, OP_PLV, OP_ENTRY, OP_END
    } op_t;

    // For OP_EX the mask field carries {subcode, ecode} and data the PC
    typedef struct packed {
        op_t                op;
        csr_pkg::csr_addr_t addr;
        logic [31:0]        mask;
        logic [31:0]        data;
        logic [31:0]        want;
    } step_t;

    localparam logic [31:0] ALL_ONES = 32'hffff_ffff;
    localparam logic [31:0] PART_MASKS [4] = '{
        32'h0000_ffff, 32'hff00_ff00, 32'h0f0f_0f0f, 32'h8000_0001
    };

    logic                         clk;
    logic                         reset;
    csr_pkg::csr_addr_t           csr_raddr;
    logic                         csr_we;
    csr_pkg::csr_addr_t           csr_waddr;
    csr_pkg::csr_data_t           csr_wmask;
    csr_pkg::csr_data_t           csr_wdata;
    logic                         wb_ex;
    csr_pkg::ecode_t              wb_ecode;
    csr_pkg::esubcode_t           wb_esubcode;
    csr_pkg::csr_data_t           wb_pc;
    logic                         ertn_flush;
    logic [7:0]                   hw_int_in;
    logic                         ipi_int_in;
    csr_pkg::csr_data_t           csr_rdata;
    logic                         has_int;
    csr_pkg::csr_data_t           ex_entry;
    csr_pkg::plv_t                crmd_plv;

    step_t       steps[$];
    int          table_cycles;
    int          limit_cycles;
    int          pass_count;
    int          fail_count;
    int          test_checks;
    int          test_fails;
    logic [31:0] rng_state;

    csr_regfile #(
        .SAVE_COUNT(4)
    ) uut (
        .clk        (clk),
        .reset      (reset),
        .csr_raddr  (csr_raddr),
        .csr_we     (csr_we),
        .csr_waddr  (csr_waddr),
        .csr_wmask  (csr_wmask),
        .csr_wdata  (csr_wdata),
        .wb_ex      (wb_ex),
        .wb_ecode   (wb_ecode),
        .wb_esubcode(wb_esubcode),
        .wb_pc      (wb_pc),
        .ertn_flush (ertn_flush),
        .hw_int_in  (hw_int_in),
        .ipi_int_in (ipi_int_in),
        .csr_rdata  (csr_rdata),
        .has_int    (has_int),
        .ex_entry   (ex_entry),
        .crmd_plv   (crmd_plv)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int step_cost(input step_t s);
        case (s.op)
            OP_IDLE:        return int'(s.data);
            OP_IRQ, OP_END: return 0;
            default:        return 1;
        endcase
    endfunction

    // Periodic counter n edges after the load: 4*INITV down to 0, then reload
    function automatic logic [31:0] periodic_count(input int n, input int initv);
        int period;
        period = 4 * initv + 1;
        return 32'(4 * initv - n % period);
    endfunction

    task automatic add_step(input op_t op, input csr_pkg::csr_addr_t addr,
                            input logic [31:0] mask, input logic [31:0] data,
                            input logic [31:0] want);
        step_t s;
        s.op   = op;
        s.addr = addr;
        s.mask = mask;
        s.data = data;
        s.want = want;
        steps.push_back(s);
        table_cycles += step_cost(s);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        test_checks++;
        if (got !== want) begin
            $display("Mismatch at %0d ns: %s is %h, expected %h", $time, name, got, want);
            fail_count++;
            test_fails++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic build_table;
        logic [31:0]        first_val;
        logic [31:0]        merged;
        csr_pkg::csr_addr_t save_addr;
        logic [31:0]        estat_want;
        int                 load_mark;
        // Reset state
        add_step(OP_READ, csr_pkg::CSR_CRMD, ALL_ONES, '0, 32'h0000_0008);
        add_step(OP_INT, '0, '0, '0, '0);
        add_step(OP_PLV, '0, '0, '0, '0);
        add_step(OP_READ, csr_pkg::CSR_TVAL, ALL_ONES, '0, ALL_ONES);
        add_step(OP_READ, csr_pkg::CSR_ECFG, ALL_ONES, '0, '0);
        add_step(OP_END, '0, '0, 32'd1, '0);
        // Scratch registers, full write then partial write
        for (int i = 0; i < 4; i++) begin
            save_addr = csr_pkg::CSR_SAVE0 + 14'(i);
            rng_state = xorshift32(rng_state);
            first_val = rng_state;
            add_step(OP_WRITE, save_addr, ALL_ONES, first_val, '0);
            add_step(OP_READ, save_addr, ALL_ONES, '0, first_val);
            rng_state = xorshift32(rng_state);
            merged = (PART_MASKS[i] & rng_state) | (~PART_MASKS[i] & first_val);
            add_step(OP_WRITE, save_addr, PART_MASKS[i], rng_state, '0);
            add_step(OP_READ, save_addr, ALL_ONES, '0, merged);
        end
        add_step(OP_READ, csr_pkg::CSR_SAVE0 + 14'd4, ALL_ONES, '0, '0);
        // ECFG bit 10 is read-only zero
        add_step(OP_WRITE, csr_pkg::CSR_ECFG, ALL_ONES, 32'h0000_1fff, '0);
        add_step(OP_READ, csr_pkg::CSR_ECFG, ALL_ONES, '0, 32'h0000_1bff);
        add_step(OP_WRITE, csr_pkg::CSR_ECFG, 32'h0000_0003, '0, '0);
        add_step(OP_READ, csr_pkg::CSR_ECFG, ALL_ONES, '0, 32'h0000_1bfc);
        add_step(OP_WRITE, csr_pkg::CSR_ECFG, ALL_ONES, '0, '0);
        add_step(OP_READ, csr_pkg::CSR_ECFG, ALL_ONES, '0, '0);
        add_step(OP_WRITE, csr_pkg::CSR_EENTRY, ALL_ONES, 32'h1c00_8abc, '0);
        add_step(OP_READ, csr_pkg::CSR_EENTRY, ALL_ONES, '0, 32'h1c00_8a80);
        add_step(OP_ENTRY, '0, '0, '0, 32'h1c00_8a80);
        add_step(OP_WRITE, csr_pkg::CSR_EENTRY, 32'hffff_0000, 32'h2d40_0000, '0);
        add_step(OP_READ, csr_pkg::CSR_EENTRY, ALL_ONES, '0, 32'h2d40_8a80);
        add_step(OP_ENTRY, '0, '0, '0, 32'h2d40_8a80);
        add_step(OP_END, '0, '0, 32'd2, '0);
        // Exception entry and return, ecode 0x0b and subcode 0x1a5
        estat_want = (32'h1a5 << 22) | (32'h0b << 16);
        add_step(OP_WRITE, csr_pkg::CSR_CRMD, ALL_ONES, 32'h0000_000f, '0);
        add_step(OP_READ, csr_pkg::CSR_CRMD, ALL_ONES, '0, 32'h0000_000f);
        add_step(OP_PLV, '0, '0, '0, 32'd3);
        add_step(OP_EX, '0, {17'd0, 9'h1a5, 6'h0b}, 32'h1c00_0140, '0);
        add_step(OP_READ, csr_pkg::CSR_ERA, ALL_ONES, '0, 32'h1c00_0140);
        add_step(OP_READ, csr_pkg::CSR_PRMD, 32'h0000_0007, '0, 32'h0000_0007);
        add_step(OP_READ, csr_pkg::CSR_CRMD, ALL_ONES, '0, 32'h0000_0008);
        add_step(OP_PLV, '0, '0, '0, '0);
        add_step(OP_READ, csr_pkg::CSR_ESTAT, 32'h7fff_0000, '0, estat_want);
        add_step(OP_ERTN, '0, '0, '0, '0);
        add_step(OP_READ, csr_pkg::CSR_CRMD, ALL_ONES, '0, 32'h0000_000f);
        add_step(OP_PLV, '0, '0, '0, 32'd3);
        add_step(OP_END, '0, '0, 32'd3, '0);
        // Software bit 0, then hardware line 3 at bit 5, then IPI
        add_step(OP_WRITE, csr_pkg::CSR_ESTAT, 32'h0000_0003, 32'h0000_0001, '0);
        add_step(OP_READ, csr_pkg::CSR_ESTAT, 32'h0000_1fff, '0, 32'h0000_0001);
        add_step(OP_INT, '0, '0, '0, '0);
        add_step(OP_WRITE, csr_pkg::CSR_ECFG, ALL_ONES, 32'h0000_0001, '0);
        add_step(OP_INT, '0, '0, '0, 32'd1);
        add_step(OP_WRITE, csr_pkg::CSR_CRMD, 32'h0000_0004, '0, '0);
        add_step(OP_INT, '0, '0, '0, '0);
        add_step(OP_WRITE, csr_pkg::CSR_CRMD, 32'h0000_0004, 32'h0000_0004, '0);
        add_step(OP_INT, '0, '0, '0, 32'd1);
        add_step(OP_WRITE, csr_pkg::CSR_ECFG, ALL_ONES, '0, '0);
        add_step(OP_INT, '0, '0, '0, '0);
        add_step(OP_WRITE, csr_pkg::CSR_ECFG, ALL_ONES, 32'h0000_0001, '0);
        add_step(OP_WRITE, csr_pkg::CSR_ESTAT, 32'h0000_0003, '0, '0);
        add_step(OP_INT, '0, '0, '0, '0);
        add_step(OP_WRITE, csr_pkg::CSR_ECFG, ALL_ONES, 32'h0000_0020, '0);
        add_step(OP_IRQ, '0, '0, 32'h0000_0008, '0);
        add_step(OP_INT, '0, '0, '0, '0);
        add_step(OP_INT, '0, '0, '0, 32'd1);
        add_step(OP_READ, csr_pkg::CSR_ESTAT, 32'h0000_1fff, '0, 32'h0000_0020);
        add_step(OP_WRITE, csr_pkg::CSR_ECFG, ALL_ONES, '0, '0);
        add_step(OP_INT, '0, '0, '0, '0);
        add_step(OP_WRITE, csr_pkg::CSR_ECFG, ALL_ONES, 32'h0000_0020, '0);
        add_step(OP_INT, '0, '0, '0, 32'd1);
        add_step(OP_WRITE, csr_pkg::CSR_CRMD, 32'h0000_0004, '0, '0);
        add_step(OP_INT, '0, '0, '0, '0);
        add_step(OP_WRITE, csr_pkg::CSR_CRMD, 32'h0000_0004, 32'h0000_0004, '0);
        add_step(OP_INT, '0, '0, '0, 32'd1);
        add_step(OP_IRQ, '0, '0, '0, '0);
        add_step(OP_INT, '0, '0, '0, 32'd1);
        add_step(OP_INT, '0, '0, '0, '0);
        add_step(OP_WRITE, csr_pkg::CSR_ECFG, ALL_ONES, 32'h0000_1000, '0);
        add_step(OP_IRQ, '0, '0, 32'h0000_0100, '0);
        add_step(OP_INT, '0, '0, '0, '0);
        add_step(OP_INT, '0, '0, '0, 32'd1);
        add_step(OP_IRQ, '0, '0, '0, '0);
        add_step(OP_IDLE, '0, '0, 32'd1, '0);
        add_step(OP_INT, '0, '0, '0, '0);
        add_step(OP_WRITE, csr_pkg::CSR_ECFG, ALL_ONES, '0, '0);
        add_step(OP_END, '0, '0, 32'd4, '0);
        // One-shot, INITV 3 so the counter starts at 12
        add_step(OP_WRITE, csr_pkg::CSR_TCFG, ALL_ONES, 32'h0000_000d, '0);
        add_step(OP_READ, csr_pkg::CSR_TVAL, ALL_ONES, '0, 32'd12);
        add_step(OP_READ, csr_pkg::CSR_TCFG, ALL_ONES, '0, 32'h0000_000d);
        add_step(OP_IDLE, '0, '0, 32'd16, '0);
        add_step(OP_READ, csr_pkg::CSR_TVAL, ALL_ONES, '0, ALL_ONES);
        add_step(OP_READ, csr_pkg::CSR_ESTAT, 32'h0000_0800, '0, 32'h0000_0800);
        add_step(OP_INT, '0, '0, '0, '0);
        add_step(OP_WRITE, csr_pkg::CSR_ECFG, ALL_ONES, 32'h0000_0800, '0);
        add_step(OP_INT, '0, '0, '0, 32'd1);
        add_step(OP_WRITE, csr_pkg::CSR_TICLR, ALL_ONES, 32'h0000_0001, '0);
        add_step(OP_READ, csr_pkg::CSR_ESTAT, 32'h0000_0800, '0, '0);
        add_step(OP_INT, '0, '0, '0, '0);
        add_step(OP_READ, csr_pkg::CSR_TICLR, ALL_ONES, '0, '0);
        add_step(OP_WRITE, csr_pkg::CSR_ECFG, ALL_ONES, '0, '0);
        add_step(OP_END, '0, '0, 32'd5, '0);
        // Periodic, INITV 4 gives a period of 17 cycles
        add_step(OP_WRITE, csr_pkg::CSR_TCFG, ALL_ONES, 32'h0000_0013, '0);
        load_mark = table_cycles;
        add_step(OP_READ, csr_pkg::CSR_TVAL, ALL_ONES, '0, periodic_count(0, 4));
        for (int k = 0; k < 6; k++) begin
            add_step(OP_IDLE, '0, '0, 32'd6, '0);
            add_step(OP_READ, csr_pkg::CSR_TVAL, ALL_ONES, '0,
                     periodic_count(table_cycles - load_mark, 4));
        end
        add_step(OP_READ, csr_pkg::CSR_ESTAT, 32'h0000_0800, '0, 32'h0000_0800);
        add_step(OP_WRITE, csr_pkg::CSR_TICLR, ALL_ONES, 32'h0000_0001, '0);
        add_step(OP_READ, csr_pkg::CSR_ESTAT, 32'h0000_0800, '0, '0);
        add_step(OP_IDLE, '0, '0, 32'd18, '0);
        add_step(OP_READ, csr_pkg::CSR_ESTAT, 32'h0000_0800, '0, 32'h0000_0800);
        add_step(OP_END, '0, '0, 32'd6, '0);
    endtask

    // Every step starts on a falling edge; checks sample mid low phase
    task automatic apply_step(input step_t s);
        case (s.op)
            OP_WRITE: begin
                csr_we    = 1'b1;
                csr_waddr = s.addr;
                csr_wmask = s.mask;
                csr_wdata = s.data;
                @(negedge clk);
                csr_we    = 1'b0;
            end
            OP_READ: begin
                csr_raddr = s.addr;
                #25;
                check_value($sformatf("csr_rdata[%03h]", s.addr), csr_rdata & s.mask, s.want);
                @(negedge clk);
            end
            OP_EX: begin
                wb_ex       = 1'b1;
                wb_ecode    = s.mask[5:0];
                wb_esubcode = s.mask[14:6];
                wb_pc       = s.data;
                @(negedge clk);
                wb_ex       = 1'b0;
            end
            OP_ERTN: begin
                ertn_flush = 1'b1;
                @(negedge clk);
                ertn_flush = 1'b0;
            end
            OP_IDLE: begin
                repeat (s.data) @(negedge clk);
            end
            OP_IRQ: begin
                hw_int_in  = s.data[7:0];
                ipi_int_in = s.data[8];
            end
            OP_INT: begin
                #25;
                check_value("has_int", {31'd0, has_int}, s.want);
                @(negedge clk);
            end
            OP_PLV: begin
                #25;
                check_value("crmd_plv", {30'd0, crmd_plv}, s.want);
                @(negedge clk);
            end
            OP_ENTRY: begin
                #25;
                check_value("ex_entry", ex_entry, s.want);
                @(negedge clk);
            end
            default: begin
                $display("Test %0d done: %0d checks, %0d mismatches",
                         s.data, test_checks, test_fails);
                test_checks = 0;
                test_fails  = 0;
            end
        endcase
    endtask

    initial begin
        wait (limit_cycles > 0);
        #(limit_cycles * 100);
        $display("Timeout: the stimulus table did not finish within %0d cycles", limit_cycles);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        reset       = 1'b1;
        csr_raddr   = '0;
        csr_we      = 1'b0;
        csr_waddr   = '0;
        csr_wmask   = '0;
        csr_wdata   = '0;
        wb_ex       = 1'b0;
        wb_ecode    = '0;
        wb_esubcode = '0;
        wb_pc       = '0;
        ertn_flush  = 1'b0;
        hw_int_in   = '0;
        ipi_int_in  = 1'b0;
        rng_state   = 32'd1;
        pass_count  = 0;
        fail_count  = 0;
        test_checks = 0;
        test_fails  = 0;
        table_cycles = 0;
        build_table();
        // Reset cycles plus slack on top of the table length
        limit_cycles = table_cycles + 3 + 50;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        foreach (steps[i]) begin
            apply_step(steps[i]);
        end
        $display("Checks passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
